// File: logic/serdes_pkg.sv
`default_nettype none

package serdes_pkg;

	// axi-lite and stream widths
	localparam int addr_width = 12;
	localparam int data_width = 32;
	localparam int strb_width = 4;

	// serial link shape
	localparam int phase_count = 4;
	localparam int phase_width = 2;
	localparam int data_lane_count = 8;
	localparam int lane_count = 12;

	// sideband lanes above the data lanes
	localparam int lane_strb = 8;
	localparam int lane_keep = 9;
	localparam int lane_iduser = 10;
	localparam int lane_ctl = 11;

	// bit order of the control nibble on lane_ctl
	localparam int ctl_ready_bit = 0;
	localparam int ctl_valid_bit = 1;
	localparam int ctl_last_bit = 2;

	// register map
	localparam logic [addr_width-1:0] reg_ctrl_offset = '0;
	localparam int ctrl_rxen_bit = 0;
	localparam int ctrl_txen_bit = 1;

	typedef logic [phase_width-1:0] phase_t;
	typedef logic [lane_count-1:0] lanes_t;

	localparam phase_t last_phase = phase_t'(phase_count - 1);

	typedef struct packed {
		logic [data_width-1:0] data;
		logic [strb_width-1:0] strb;
		logic [strb_width-1:0] keep;
		logic [1:0] id;
		logic [1:0] user;
		logic last;
	} axis_beat_t;

endpackage

`default_nettype wire

// File: logic/link_if.sv
`timescale 1ns/1ns
`default_nettype none

interface link_if;
	import serdes_pkg::*;

	logic txen;
	logic rxen;
	phase_t phase;          // free running, shared by both directions
	logic rx_received;
	logic remote_ready;

	////////////////////
	// control owns the enables and the phase, rx reports back
	modport ctrl (
		output txen, rxen, phase,
		input  rx_received, remote_ready
	);

	modport tx (input txen, phase);

	modport rx (
		input  rxen,
		output rx_received, remote_ready
	);

endinterface

`default_nettype wire

// File: logic/axil_ctrl_regs.sv
`timescale 1ns/1ns
`default_nettype none

module axil_ctrl_regs (
	input  logic axi_clk,
	input  logic axi_reset_n,
	input  logic cc_ls_enable,
	input  logic awvalid,
	input  logic [serdes_pkg::addr_width-1:0] awaddr,
	output logic awready,
	input  logic wvalid,
	input  logic [serdes_pkg::data_width-1:0] wdata,
	input  logic [serdes_pkg::strb_width-1:0] wstrb,
	output logic wready,
	input  logic arvalid,
	input  logic [serdes_pkg::addr_width-1:0] araddr,
	output logic arready,
	output logic rvalid,
	output logic [serdes_pkg::data_width-1:0] rdata,
	input  logic rready,
	output logic txen_ctl,
	output logic rxen_ctl
);
	import serdes_pkg::*;

	typedef enum logic [1:0] {w_idle, w_addr_done, w_both_done} w_state_t;
	typedef enum logic [1:0] {r_idle, r_addr_done, r_response} r_state_t;

	w_state_t w_state;
	r_state_t r_state;
	logic waddr_full;
	logic wdata_full;
	logic raddr_full;
	logic aw_take;
	logic w_take;
	logic ar_take;
	logic [addr_width-1:0] waddr_buf;
	logic [addr_width-1:0] raddr_buf;
	logic [1:0] en_buf;     // rx enable at 0, tx enable at 1
	logic strb0_buf;

	assign awready = !waddr_full;
	assign wready = !wdata_full;
	assign arready = !raddr_full;

	// requests only count while the bus is enabled
	assign aw_take = awvalid && cc_ls_enable && awready;
	assign w_take = wvalid && cc_ls_enable && wready;
	assign ar_take = arvalid && cc_ls_enable && arready;

	////////////////////
	// write side
	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			waddr_full <= 1'b0;
			wdata_full <= 1'b0;
			w_state <= w_idle;
		end else begin
			if (aw_take)
				waddr_full <= 1'b1;
			else if (w_state == w_both_done)
				waddr_full <= 1'b0;
			if (w_take)
				wdata_full <= 1'b1;
			else if (w_state == w_both_done)
				wdata_full <= 1'b0;
			case (w_state)
				w_idle:
					if (waddr_full && wdata_full)
						w_state <= w_both_done;
					else if (waddr_full)
						w_state <= w_addr_done;
				w_addr_done:
					if (wdata_full)
						w_state <= w_both_done;
				default:
					w_state <= w_idle;
			endcase
		end
	end

	always_ff @(posedge axi_clk) begin
		if (aw_take)
			waddr_buf <= awaddr;
		if (w_take) begin
			en_buf <= {wdata[ctrl_txen_bit], wdata[ctrl_rxen_bit]};
			strb0_buf <= wstrb[0];
		end
	end

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			rxen_ctl <= 1'b0;
			txen_ctl <= 1'b0;
		end else if (w_state == w_both_done && waddr_buf == reg_ctrl_offset && strb0_buf) begin
			rxen_ctl <= en_buf[0];
			txen_ctl <= en_buf[1];
		end
	end

	////////////////////
	// read side
	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			raddr_full <= 1'b0;
			rvalid <= 1'b0;
			r_state <= r_idle;
		end else begin
			if (ar_take)
				raddr_full <= 1'b1;
			else if (r_state == r_addr_done)
				raddr_full <= 1'b0;     // address consumed, accept the next one
			if (rvalid && rready)
				rvalid <= 1'b0;
			else if (r_state == r_response)
				rvalid <= 1'b1;
			case (r_state)
				r_idle:
					if (raddr_full)
						r_state <= r_addr_done;
				r_addr_done:
					r_state <= r_response;
				default:
					if (rvalid && rready)
						r_state <= r_idle;
			endcase
		end
	end

	always_ff @(posedge axi_clk) begin
		if (ar_take)
			raddr_buf <= araddr;
		if (r_state == r_addr_done) begin
			rdata <= '0;    // unmapped offsets read as zero
			if (raddr_buf == reg_ctrl_offset) begin
				rdata[ctrl_rxen_bit] <= rxen_ctl;
				rdata[ctrl_txen_bit] <= txen_ctl;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/link_control.sv
`timescale 1ns/1ns
`default_nettype none

module link_control (
	input  logic axi_clk,
	input  logic axi_reset_n,
	input  logic txen_ctl,
	input  logic rxen_ctl,
	link_if.ctrl link,
	output logic local_ready
);
	import serdes_pkg::*;

	// phase runs from reset on, both directions use it
	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n)
			link.phase <= '0;
		else
			link.phase <= link.phase + 1'b1;
	end

	////////////////////
	// sticky enables
	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			link.txen <= 1'b0;
			link.rxen <= 1'b0;
		end else begin
			// a word from the far end also turns tx on,
			// so our ready bit reaches the remote side
			if (link.phase == last_phase && (txen_ctl || link.rx_received))
				link.txen <= 1'b1;
			if (rxen_ctl)
				link.rxen <= 1'b1;
		end
	end

	////////////////////
	// ready towards the local sender
	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			local_ready <= 1'b0;
		end else begin
			if (!link.txen)
				local_ready <= 1'b0;
			else if (!link.rx_received)
				local_ready <= 1'b1;    // nothing heard yet, avoid deadlock
			else
				local_ready <= link.remote_ready;
		end
	end

endmodule

`default_nettype wire

// File: logic/tx_serializer.sv
`timescale 1ns/1ns
`default_nettype none

module tx_serializer (
	input  logic axi_clk,
	input  logic axi_reset_n,
	link_if.tx link,
	input  serdes_pkg::axis_beat_t beat,
	input  logic beat_valid,
	input  logic local_ready,
	input  logic peer_ready,
	output serdes_pkg::lanes_t txd,
	output logic tsync
);
	import serdes_pkg::*;

	axis_beat_t beat_q;
	logic valid_q;
	logic ready_q;
	logic [phase_count-1:0] iduser_nib;
	logic [phase_count-1:0] ctl_nib;
	lanes_t lanes;

	////////////////////
	// capture at the end of each word slot
	always_ff @(posedge axi_clk) begin
		if (link.phase == last_phase)
			beat_q <= beat;
	end

	// valid only goes out when the sender was actually accepted;
	// local_ready is low while tx is off, so early slots carry no valid
	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			valid_q <= 1'b0;
			ready_q <= 1'b0;
		end else if (link.phase == last_phase) begin
			valid_q <= beat_valid && local_ready;
			ready_q <= peer_ready;
		end
	end

	assign iduser_nib = {beat_q.id, beat_q.user};   // id in the upper half

	always_comb begin
		ctl_nib = '0;
		ctl_nib[ctl_ready_bit] = ready_q;
		ctl_nib[ctl_valid_bit] = valid_q;
		ctl_nib[ctl_last_bit] = beat_q.last;
	end

	////////////////////
	// one bit per lane per phase
	always_comb begin
		lanes = '0;
		for (int k = 0; k < data_lane_count; k++)
			lanes[k] = beat_q.data[k*phase_count + link.phase];
		lanes[lane_strb] = beat_q.strb[link.phase];
		lanes[lane_keep] = beat_q.keep[link.phase];
		lanes[lane_iduser] = iduser_nib[link.phase];
		lanes[lane_ctl] = ctl_nib[link.phase];
	end

	assign txd = link.txen ? lanes : '0;            // quiet link until enabled
	assign tsync = link.txen && (link.phase == '0); // marks phase 0

endmodule

`default_nettype wire

// File: logic/rx_deserializer.sv
`timescale 1ns/1ns
`default_nettype none

module rx_deserializer (
	input  logic axi_clk,
	input  logic axi_reset_n,
	link_if.rx link,
	input  serdes_pkg::lanes_t rxd,
	input  logic rsync,
	output serdes_pkg::axis_beat_t beat,
	output logic beat_valid
);
	import serdes_pkg::*;

	logic [phase_count-1:0] sr [lane_count];    // phase p ends up in bit p
	phase_t cnt;
	logic collecting;
	logic word_done;
	logic start;

	assign start = link.rxen && rsync;

	////////////////////
	// lane shift registers
	always_ff @(posedge axi_clk) begin
		if (start || collecting) begin
			for (int k = 0; k < lane_count; k++)
				sr[k] <= {rxd[k], sr[k][phase_count-1:1]};
		end
	end

	// sync restarts the count, so alignment follows the far end
	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			cnt <= '0;
			collecting <= 1'b0;
			word_done <= 1'b0;
		end else begin
			word_done <= 1'b0;
			if (start) begin
				cnt <= phase_t'(1);   // phase 0 taken this cycle
				collecting <= 1'b1;
			end else if (collecting) begin
				cnt <= cnt + 1'b1;
				if (cnt == last_phase) begin
					collecting <= 1'b0;
					word_done <= 1'b1;
				end
			end
		end
	end

	////////////////////
	// reassembly
	always_comb begin
		for (int k = 0; k < data_lane_count; k++) begin
			for (int p = 0; p < phase_count; p++)
				beat.data[k*phase_count + p] = sr[k][p];
		end
		beat.strb = sr[lane_strb];
		beat.keep = sr[lane_keep];
		{beat.id, beat.user} = sr[lane_iduser];
		beat.last = sr[lane_ctl][ctl_last_bit];
	end

	assign beat_valid = word_done && sr[lane_ctl][ctl_valid_bit];   // one cycle only

	// status back to link control
	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			link.rx_received <= 1'b0;
			link.remote_ready <= 1'b0;
		end else if (word_done) begin
			link.rx_received <= 1'b1;
			link.remote_ready <= sr[lane_ctl][ctl_ready_bit];
		end
	end

endmodule

`default_nettype wire

// File: logic/io_serdes.sv
`timescale 1ns/1ns
`default_nettype none

module io_serdes (
	input  logic axi_clk,
	input  logic axi_reset_n,

	// axi-lite control port
	input  logic axi_awvalid,
	input  logic [serdes_pkg::addr_width-1:0] axi_awaddr,
	output logic axi_awready,
	input  logic axi_wvalid,
	input  logic [serdes_pkg::data_width-1:0] axi_wdata,
	input  logic [serdes_pkg::strb_width-1:0] axi_wstrb,
	output logic axi_wready,
	input  logic axi_arvalid,
	input  logic [serdes_pkg::addr_width-1:0] axi_araddr,
	output logic axi_arready,
	output logic axi_rvalid,
	output logic [serdes_pkg::data_width-1:0] axi_rdata,
	input  logic axi_rready,
	input  logic cc_ls_enable,

	// stream from the local switch
	input  logic [serdes_pkg::data_width-1:0] as_is_tdata,
	input  logic [serdes_pkg::strb_width-1:0] as_is_tstrb,
	input  logic [serdes_pkg::strb_width-1:0] as_is_tkeep,
	input  logic [1:0] as_is_tid,
	input  logic [1:0] as_is_tuser,
	input  logic as_is_tlast,
	input  logic as_is_tvalid,
	input  logic as_is_tready,   // local receive side can take more

	// serial lanes
	output serdes_pkg::lanes_t serial_txd,
	output logic serial_tsync,
	input  serdes_pkg::lanes_t serial_rxd,
	input  logic serial_rsync,

	// stream to the local switch
	output logic [serdes_pkg::data_width-1:0] is_as_tdata,
	output logic [serdes_pkg::strb_width-1:0] is_as_tstrb,
	output logic [serdes_pkg::strb_width-1:0] is_as_tkeep,
	output logic [1:0] is_as_tid,
	output logic [1:0] is_as_tuser,
	output logic is_as_tlast,
	output logic is_as_tvalid,
	output logic is_as_tready    // remote side can take more
);
	import serdes_pkg::*;

	logic txen_ctl;
	logic rxen_ctl;
	axis_beat_t tx_beat;
	axis_beat_t rx_beat;

	link_if link ();

	assign tx_beat = '{data: as_is_tdata, strb: as_is_tstrb, keep: as_is_tkeep,
		id: as_is_tid, user: as_is_tuser, last: as_is_tlast};

	assign is_as_tdata = rx_beat.data;
	assign is_as_tstrb = rx_beat.strb;
	assign is_as_tkeep = rx_beat.keep;
	assign is_as_tid = rx_beat.id;
	assign is_as_tuser = rx_beat.user;
	assign is_as_tlast = rx_beat.last;

	axil_ctrl_regs u_regs (
		.axi_clk(axi_clk), .axi_reset_n(axi_reset_n), .cc_ls_enable(cc_ls_enable),
		.awvalid(axi_awvalid), .awaddr(axi_awaddr), .awready(axi_awready),
		.wvalid(axi_wvalid), .wdata(axi_wdata), .wstrb(axi_wstrb), .wready(axi_wready),
		.arvalid(axi_arvalid), .araddr(axi_araddr), .arready(axi_arready),
		.rvalid(axi_rvalid), .rdata(axi_rdata), .rready(axi_rready),
		.txen_ctl(txen_ctl), .rxen_ctl(rxen_ctl)
	);

	link_control u_link_ctrl (
		.axi_clk(axi_clk), .axi_reset_n(axi_reset_n),
		.txen_ctl(txen_ctl), .rxen_ctl(rxen_ctl),
		.link(link), .local_ready(is_as_tready)
	);

	tx_serializer u_tx (
		.axi_clk(axi_clk), .axi_reset_n(axi_reset_n), .link(link),
		.beat(tx_beat), .beat_valid(as_is_tvalid),
		.local_ready(is_as_tready), .peer_ready(as_is_tready),
		.txd(serial_txd), .tsync(serial_tsync)
	);

	rx_deserializer u_rx (
		.axi_clk(axi_clk), .axi_reset_n(axi_reset_n), .link(link),
		.rxd(serial_rxd), .rsync(serial_rsync),
		.beat(rx_beat), .beat_valid(is_as_tvalid)
	);

endmodule

`default_nettype wire

// File: tb/io_serdes_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module io_serdes_assertions (
	input logic axi_clk,
	input logic axi_reset_n,
	input logic txen,
	input serdes_pkg::lanes_t serial_txd,
	input logic serial_tsync,
	input logic is_as_tvalid
);
	int fail_count = 0;     // failed assertions so far

	////////////////////
	// transmit side
	quiet_lanes: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		!txen |-> serial_txd == '0)
	else begin
		$error("serial lanes driven while tx is disabled");
		fail_count++;
	end

	sync_on_enable: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		$rose(txen) |-> serial_tsync)
	else begin
		$error("no sync marker in the first enabled cycle");
		fail_count++;
	end

	// sync repeats every four cycles, once per word
	sync_period: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		(txen && serial_tsync) |=> !serial_tsync [*3] ##1 serial_tsync)
	else begin
		$error("sync marker out of its four cycle period");
		fail_count++;
	end

	////////////////////
	// receive side
	single_pulse: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		is_as_tvalid |=> !is_as_tvalid)
	else begin
		$error("is_as_tvalid high for two cycles in a row");
		fail_count++;
	end

endmodule

bind io_serdes io_serdes_assertions u_assertions (
	.axi_clk(axi_clk),
	.axi_reset_n(axi_reset_n),
	.txen(link.txen),
	.serial_txd(serial_txd),
	.serial_tsync(serial_tsync),
	.is_as_tvalid(is_as_tvalid)
);

`default_nettype wire

// File: tb/tb_io_serdes.sv
`timescale 1ns/1ns
`default_nettype none

module tb_io_serdes;
	import serdes_pkg::*;

	logic axi_clk;
	logic axi_reset_n;
	logic axi_awvalid;
	logic [addr_width-1:0] axi_awaddr;
	logic axi_awready;
	logic axi_wvalid;
	logic [data_width-1:0] axi_wdata;
	logic [strb_width-1:0] axi_wstrb;
	logic axi_wready;
	logic axi_arvalid;
	logic [addr_width-1:0] axi_araddr;
	logic axi_arready;
	logic axi_rvalid;
	logic [data_width-1:0] axi_rdata;
	logic axi_rready;
	logic cc_ls_enable;
	axis_beat_t send_beat;          // drives the as_is_* fields
	logic as_is_tvalid;
	logic as_is_tready;
	lanes_t serial_lanes;           // txd looped into rxd
	logic serial_sync;
	logic [data_width-1:0] rx_data;
	logic [strb_width-1:0] rx_strb;
	logic [strb_width-1:0] rx_keep;
	logic [1:0] rx_id;
	logic [1:0] rx_user;
	logic rx_last;
	logic is_as_tvalid;
	logic is_as_tready;

	phase_t model_phase;
	axis_beat_t send_q[$];
	axis_beat_t expect_q[$];
	axis_beat_t cur_beat;
	axis_beat_t exp_beat;
	logic sending;
	logic early_ready;              // is_as_tready seen high while no ready bit was set
	string stim_lines[$];
	logic [31:0] lfsr;
	int error_count;
	int check_count;
	int sent_count;
	int recv_count;
	int unsigned cycle_count;
	int unsigned cycle_limit = 200;

	io_serdes u_dut (
		.axi_clk(axi_clk), .axi_reset_n(axi_reset_n),
		.axi_awvalid(axi_awvalid), .axi_awaddr(axi_awaddr), .axi_awready(axi_awready),
		.axi_wvalid(axi_wvalid), .axi_wdata(axi_wdata), .axi_wstrb(axi_wstrb),
		.axi_wready(axi_wready),
		.axi_arvalid(axi_arvalid), .axi_araddr(axi_araddr), .axi_arready(axi_arready),
		.axi_rvalid(axi_rvalid), .axi_rdata(axi_rdata), .axi_rready(axi_rready),
		.cc_ls_enable(cc_ls_enable),
		.as_is_tdata(send_beat.data), .as_is_tstrb(send_beat.strb),
		.as_is_tkeep(send_beat.keep), .as_is_tid(send_beat.id),
		.as_is_tuser(send_beat.user), .as_is_tlast(send_beat.last),
		.as_is_tvalid(as_is_tvalid), .as_is_tready(as_is_tready),
		.serial_txd(serial_lanes), .serial_tsync(serial_sync),
		.serial_rxd(serial_lanes), .serial_rsync(serial_sync),
		.is_as_tdata(rx_data), .is_as_tstrb(rx_strb), .is_as_tkeep(rx_keep),
		.is_as_tid(rx_id), .is_as_tuser(rx_user), .is_as_tlast(rx_last),
		.is_as_tvalid(is_as_tvalid), .is_as_tready(is_as_tready)
	);

	initial begin
		axi_clk = 1'b0;
		forever #20 axi_clk = ~axi_clk;
	end

	// galois form, taps x^32+x^22+x^2+x+1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] lfsr_word();
		logic [31:0] w;
		for (int i = 0; i < 32; i++) begin
			lfsr = lfsr_next(lfsr);
			w[i] = lfsr[0];         // one step per bit
		end
		return w;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		check_count++;
		assert (got === exp) else begin
			$display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		check_count++;
		assert (cond) else begin
			$display("error at %0t ns: %s", $time, what);
			error_count++;
		end
	endtask

	////////////////////
	// axi-lite master
	task automatic axil_write(input logic [addr_width-1:0] addr, input logic [31:0] data,
			input logic [strb_width-1:0] strb, input logic en);
		logic aw_done;
		logic w_done;
		aw_done = 1'b0;
		w_done = 1'b0;
		axi_awaddr <= addr;
		axi_wdata <= data;
		axi_wstrb <= strb;
		axi_awvalid <= 1'b1;
		axi_wvalid <= 1'b1;
		cc_ls_enable <= en;
		if (!en) begin
			repeat (8) begin
				@(posedge axi_clk);
				check_true(axi_awready && axi_wready, "write taken while bus disabled");
			end
			axi_awvalid <= 1'b0;
			axi_wvalid <= 1'b0;
			cc_ls_enable <= 1'b1;
		end else begin
			while (!(aw_done && w_done)) begin
				@(posedge axi_clk);
				if (axi_awvalid && axi_awready) begin
					aw_done = 1'b1;
					axi_awvalid <= 1'b0;
				end
				if (axi_wvalid && axi_wready) begin
					w_done = 1'b1;
					axi_wvalid <= 1'b0;
				end
			end
		end
	endtask

	task automatic axil_read(input logic [addr_width-1:0] addr, input logic [31:0] exp);
		axi_araddr <= addr;
		axi_arvalid <= 1'b1;
		@(posedge axi_clk);
		while (!axi_arready)
			@(posedge axi_clk);
		axi_arvalid <= 1'b0;
		@(posedge axi_clk);
		while (!axi_rvalid)
			@(posedge axi_clk);
		check_value("axi_rdata", axi_rdata, exp);
	endtask

	// set the local receive ready, wait for the far end to follow
	task automatic hold_ready(input logic level, input int hold);
		as_is_tready <= level;
		@(posedge axi_clk);
		while (is_as_tready !== level)
			@(posedge axi_clk);
		repeat (hold) begin
			@(posedge axi_clk);
			check_value("is_as_tready", is_as_tready, level);
		end
	endtask

	////////////////////
	// link model and stream processes
	always @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n)
			model_phase <= '0;
		else
			model_phase <= model_phase + 1'b1;  // free running from reset
	end

	// only the forced ready can raise is_as_tready while every ready bit sent is low
	always @(posedge axi_clk) begin
		if (axi_reset_n && is_as_tready === 1'b1 && !as_is_tready)
			early_ready <= 1'b1;
	end

	always @(posedge axi_clk) begin
		if (sending && model_phase == last_phase && is_as_tready) begin
			expect_q.push_back(cur_beat);           // accepted at this slot edge
			sent_count++;
			sending = 1'b0;
			as_is_tvalid <= 1'b0;
		end
		if (!sending && send_q.size() > 0) begin
			cur_beat = send_q.pop_front();
			send_beat <= cur_beat;
			as_is_tvalid <= 1'b1;
			sending = 1'b1;
		end
	end

	always @(posedge axi_clk) begin
		if (axi_reset_n && is_as_tvalid) begin
			recv_count++;
			if (expect_q.size() == 0) begin
				check_true(1'b0, "valid word received with no accepted beat behind it");
			end else begin
				exp_beat = expect_q.pop_front();
				check_value("is_as_tdata", rx_data, exp_beat.data);
				check_value("is_as_tstrb", rx_strb, exp_beat.strb);
				check_value("is_as_tkeep", rx_keep, exp_beat.keep);
				check_value("is_as_tid", rx_id, exp_beat.id);
				check_value("is_as_tuser", rx_user, exp_beat.user);
				check_value("is_as_tlast", rx_last, exp_beat.last);
			end
		end
	end

	initial begin : watchdog
		cycle_count = 0;
		@(posedge axi_clk);
		while (cycle_count < cycle_limit) begin
			@(posedge axi_clk);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
		$display("TEST FAILED");
		$finish;
	end

	////////////////////
	// main sequence
	initial begin : main
		int fd;
		int n;
		int errors_before;
		string line;
		string tok;
		logic [31:0] a, d, s, k, i, u, l;
		axis_beat_t b;
		logic ready_cmd_seen;
		axi_reset_n = 1'b0;
		axi_awvalid = 1'b0;
		axi_awaddr = '0;
		axi_wvalid = 1'b0;
		axi_wdata = '0;
		axi_wstrb = '0;
		axi_arvalid = 1'b0;
		axi_araddr = '0;
		axi_rready = 1'b1;
		cc_ls_enable = 1'b1;
		send_beat = '0;
		as_is_tvalid = 1'b0;
		as_is_tready = 1'b0;    // far end sees no room until the first ready command
		sending = 1'b0;
		early_ready = 1'b0;
		ready_cmd_seen = 1'b0;
		lfsr = 32'h750e;
		error_count = 0;
		check_count = 0;
		sent_count = 0;
		recv_count = 0;
		fd = $fopen("tb/io_serdes_stim.txt", "r");
		if (fd == 0) begin
			$display("error: could not open tb/io_serdes_stim.txt");
			error_count++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
					if (line.getc(line.len() - 1) == "\n")
						line = line.substr(0, line.len() - 2);
					stim_lines.push_back(line);
				end
			end
			$fclose(fd);
		end
		cycle_limit = 40 * stim_lines.size() + 200;

		repeat (2) @(posedge axi_clk);
		axi_reset_n <= 1'b1;
		@(posedge axi_clk);
		check_value("is_as_tready", is_as_tready, 0);
		check_value("serial_txd", serial_lanes, 0);
		$display("test 0 reset state: %0s", (error_count == 0) ? "passed" : "errors");

		foreach (stim_lines[idx]) begin
			line = stim_lines[idx];
			errors_before = error_count;
			case (line.getc(0))
				"W": begin
					n = $sscanf(line, "W %h %h %h %h", a, d, s, l);
					check_true(n == 4, "malformed write line in stim file");
					axil_write(a[addr_width-1:0], d, s[strb_width-1:0], l[0]);
				end
				"R": begin
					n = $sscanf(line, "R %h %h", a, d);
					check_true(n == 2, "malformed read line in stim file");
					axil_read(a[addr_width-1:0], d);
				end
				"B": begin
					n = $sscanf(line, "B %s %h %h %h %h %h", tok, s, k, i, u, l);
					check_true(n == 6, "malformed beat line in stim file");
					b.data = (tok == "X") ? lfsr_word() : tok.atohex();
					b.strb = s[strb_width-1:0];
					b.keep = k[strb_width-1:0];
					b.id = i[1:0];
					b.user = u[1:0];
					b.last = l[0];
					send_q.push_back(b);    // the sender process offers it
				end
				"P": begin
					n = $sscanf(line, "P %h %d", l, d);
					check_true(n == 2, "malformed ready line in stim file");
					if (!ready_cmd_seen) begin
						check_true(early_ready,
							"is_as_tready stayed low after the link was enabled");
						ready_cmd_seen = 1'b1;
					end
					hold_ready(l[0], d);
				end
				default: check_true(1'b0, "unknown command in stim file");
			endcase
			$display("test %0d [%0s]: %0s", idx + 1, line,
				(error_count == errors_before) ? "passed" : "errors");
		end

		while (sending || send_q.size() > 0 || expect_q.size() > 0)
			@(posedge axi_clk);
		repeat (12) @(posedge axi_clk);    // room for a stray word
		check_value("received beat count", recv_count, sent_count);
		$display("test %0d loopback: %0d beats accepted, %0d delivered",
			stim_lines.size() + 1, sent_count, recv_count);
		error_count += u_dut.u_assertions.fail_count;
		$display("checks %0d, errors %0d, assertion failures %0d",
			check_count, error_count, u_dut.u_assertions.fail_count);
		if (error_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/io_serdes_stim.txt
# W addr data strb en | R addr expected_data | P level hold_cycles(decimal)
# B data strb keep id user last, all hex; data X takes 32 lfsr bits
R 000 00000000
W 000 00000003 1 1
R 000 00000003
W 000 00000000 0 1
R 000 00000003
R 004 00000000
W 000 00000000 1 0
R 000 00000003
P 1 4
B 12345678 f f 1 2 0
B X 3 f 0 1 0
B X f 7 3 3 1
B a5a5a5a5 1 1 2 0 1
P 0 4
B 0badf00d c f 1 1 1
P 0 20
P 1 8
B X 5 a 0 3 1
B X f f 2 2 0

// File: project.f
logic/serdes_pkg.sv
logic/link_if.sv
logic/axil_ctrl_regs.sv
logic/link_control.sv
logic/tx_serializer.sv
logic/rx_deserializer.sv
logic/io_serdes.sv
tb/io_serdes_assertions.sv
tb/tb_io_serdes.sv

// File: Bender.yml
package:
  name: io_serdes

sources:
  - files:
      - logic/serdes_pkg.sv
      - logic/link_if.sv
      - logic/axil_ctrl_regs.sv
      - logic/link_control.sv
      - logic/tx_serializer.sv
      - logic/rx_deserializer.sv
      - logic/io_serdes.sv
  - target: test
    files:
      - tb/io_serdes_assertions.sv
      - tb/tb_io_serdes.sv
